//--- rf_pkg.sv
/*
 * shared types and constants for the two-lane execution subsystem
 * referenced by scoped name from the lanes, the register file and the top
 */
`default_nettype none

package rf_pkg;

  // alu opcodes, 3 bits wide
  typedef enum logic [2:0] {
    // rd <= immediate
    OP_LI  = 3'd0,
    // two-operand arithmetic and logic on rs1, rs2
    OP_ADD = 3'd1,
    OP_SUB = 3'd2,
    OP_AND = 3'd3,
    OP_OR  = 3'd4,
    OP_XOR = 3'd5,
    // shifts of rs1 by the low bits of rs2
    OP_SLL = 3'd6,
    OP_SRL = 3'd7
  } alu_op_e;

  // multiply lane FSM
  typedef enum logic [1:0] {
    MUL_IDLE = 2'd0,
    // one shift-add step per cycle
    MUL_RUN  = 2'd1,
    // result on write port 1 for one cycle
    MUL_WB   = 2'd2
  } mul_state_e;

  // write port indices into the register file
  // higher index wins a same-register collision
  localparam int unsigned WR_PORT_ALU = 0;
  localparam int unsigned WR_PORT_MUL = 1;

  // one RAM block per write port
  localparam int unsigned NUM_WR_PORTS = 2;

endpackage

`default_nettype wire

//--- rf_read_if.sv
/*
 * two-operand register read port, addresses out and data back in one cycle
 * lanes use the requester side, the register file the provider side
 */
`timescale 1ns/10ps
`default_nettype none

interface rf_read_if #(
  parameter int unsigned DATA_WIDTH = 32,
  parameter int unsigned ADDR_WIDTH = 5
);

  // operand addresses
  logic [ADDR_WIDTH-1:0] raddr_a;
  logic [ADDR_WIDTH-1:0] raddr_b;
  // operand data, combinational
  logic [DATA_WIDTH-1:0] rdata_a;
  logic [DATA_WIDTH-1:0] rdata_b;

  // side that asks for operands
  modport requester (
    output raddr_a,
    output raddr_b,
    input  rdata_a,
    input  rdata_b
  );

  // side that returns operands
  modport provider (
    input  raddr_a,
    input  raddr_b,
    output rdata_a,
    output rdata_b
  );

endinterface

`default_nettype wire

//--- rf_lvt_regfile.sv
/*
 * FPGA-style register file, one sync-write RAM block per write port
 * a live value table picks the block holding the latest value on every read
 */
`timescale 1ns/10ps
`default_nettype none

module rf_lvt_regfile #(
  parameter int unsigned DATA_WIDTH    = 32,
  parameter int unsigned ADDR_WIDTH    = 5,
  parameter bit          ZERO_REG_ZERO = 1'b1
) (
  input  wire logic                                              clk_i,
  input  wire logic                                              arst_n_i,
  // shared operand read pair
  rf_read_if.provider                                            rd,
  // write ports, index rf_pkg::WR_PORT_*
  input  wire logic [rf_pkg::NUM_WR_PORTS-1:0]                   we_i,
  input  wire logic [rf_pkg::NUM_WR_PORTS-1:0][ADDR_WIDTH-1:0]   waddr_i,
  input  wire logic [rf_pkg::NUM_WR_PORTS-1:0][DATA_WIDTH-1:0]   wdata_i,
  // debug read port
  input  wire logic [ADDR_WIDTH-1:0]                             dbg_raddr_i,
  output logic      [DATA_WIDTH-1:0]                             dbg_rdata_o
);

  localparam int unsigned NUM_WORDS    = 2 ** ADDR_WIDTH;
  // operand a, operand b, debug
  localparam int unsigned NUM_RD_PORTS = 3;
  // width of one live value table entry
  localparam int unsigned SEL_W =
      (rf_pkg::NUM_WR_PORTS > 1) ? $clog2(rf_pkg::NUM_WR_PORTS) : 1;

  // live value table, one block index per register
  logic [NUM_WORDS-1:0][SEL_W-1:0] lvt_q;
  logic [NUM_WORDS-1:0][SEL_W-1:0] lvt_d;

  // read addresses gathered per read port
  logic [NUM_RD_PORTS-1:0][ADDR_WIDTH-1:0] raddr;
  logic [NUM_RD_PORTS-1:0][DATA_WIDTH-1:0] rdata;
  // every block read at every read address
  logic [rf_pkg::NUM_WR_PORTS-1:0][NUM_RD_PORTS-1:0][DATA_WIDTH-1:0] blk_rdata;

  assign raddr[0] = rd.raddr_a;
  assign raddr[1] = rd.raddr_b;
  assign raddr[2] = dbg_raddr_i;

  // table update, later ports overwrite earlier ones
  // so the higher index wins a collision
  always_comb begin
    lvt_d = lvt_q;
    for (int j = 0; j < rf_pkg::NUM_WR_PORTS; j++) begin
      if (we_i[j]) begin
        lvt_d[waddr_i[j]] = SEL_W'(j);
      end
    end
  end

  // table flops, all registers start out in block 0
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lvt_q <= '0;
    end else begin
      lvt_q <= lvt_d;
    end
  end

  for (genvar j = 0; j < rf_pkg::NUM_WR_PORTS; j++) begin : gen_ram_block
    logic [NUM_WORDS-1:0][DATA_WIDTH-1:0] ram_q;

    // single sync write port per block
    // cleared on reset so every register reads zero afterwards
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        ram_q <= '0;
      end else if (we_i[j]) begin
        ram_q[waddr_i[j]] <= wdata_i[j];
      end
    end

    // async reads, one per read port
    for (genvar k = 0; k < NUM_RD_PORTS; k++) begin : gen_blk_read
      assign blk_rdata[j][k] = ram_q[raddr[k]];
    end
  end

  // output mux per read port
  for (genvar k = 0; k < NUM_RD_PORTS; k++) begin : gen_read_port
    logic [SEL_W-1:0] blk_sel;

    assign blk_sel  = lvt_q[raddr[k]];
    // register 0 hardwired to zero when enabled
    assign rdata[k] = (ZERO_REG_ZERO && (raddr[k] == '0)) ? '0 : blk_rdata[blk_sel][k];
  end

  assign rd.rdata_a  = rdata[0];
  assign rd.rdata_b  = rdata[1];
  assign dbg_rdata_o = rdata[2];

endmodule

`default_nettype wire

//--- rf_read_arbiter.sv
/*
 * fixed-priority arbiter for the shared operand read pair
 * the ALU lane wins, the multiply lane gets the port and its ready otherwise
 */
`timescale 1ns/10ps
`default_nettype none

module rf_read_arbiter (
  // ALU issue this cycle, highest priority
  input  wire logic   alu_valid_i,
  // lane-facing read ports
  rf_read_if.provider alu_rd,
  rf_read_if.provider mul_rd,
  // register file facing read port
  rf_read_if.requester rf_rd,
  // multiply lane not idle
  input  wire logic   mul_busy_i,
  output logic        mul_ready_o
);

  logic alu_grant;

  // ALU owns the pair whenever it issues
  assign alu_grant = alu_valid_i;

  // address mux
  always_comb begin
    if (alu_grant) begin
      rf_rd.raddr_a = alu_rd.raddr_a;
      rf_rd.raddr_b = alu_rd.raddr_b;
    end else begin
      rf_rd.raddr_a = mul_rd.raddr_a;
      rf_rd.raddr_b = mul_rd.raddr_b;
    end
  end

  // data fans back to both lanes
  // only the granted lane acts on it
  assign alu_rd.rdata_a = rf_rd.rdata_a;
  assign alu_rd.rdata_b = rf_rd.rdata_b;
  assign mul_rd.rdata_a = rf_rd.rdata_a;
  assign mul_rd.rdata_b = rf_rd.rdata_b;

  // multiply accepted only with the read pair free and the lane idle
  // a held request waits out ALU issue cycles
  assign mul_ready_o = !alu_grant && !mul_busy_i;

endmodule

`default_nettype wire

//--- alu_lane.sv
/*
 * single-cycle ALU lane, reads rs1 and rs2 and writes rd through write port 0
 * the result lands at the same edge the instruction is sampled
 */
`timescale 1ns/10ps
`default_nettype none

module alu_lane #(
  parameter int unsigned DATA_WIDTH = 32,
  parameter int unsigned ADDR_WIDTH = 5
) (
  // issue
  input  wire logic                  alu_valid_i,
  input  wire rf_pkg::alu_op_e       alu_op_i,
  input  wire logic [ADDR_WIDTH-1:0] alu_rd_i,
  input  wire logic [ADDR_WIDTH-1:0] alu_rs1_i,
  input  wire logic [ADDR_WIDTH-1:0] alu_rs2_i,
  input  wire logic [DATA_WIDTH-1:0] alu_imm_i,
  // operand read through the arbiter
  rf_read_if.requester               rd,
  // write port 0
  output logic                       we_o,
  output logic      [ADDR_WIDTH-1:0] waddr_o,
  output logic      [DATA_WIDTH-1:0] wdata_o
);

  // shift amount width, 5 bits for 32-bit data
  localparam int unsigned SHAMT_W = $clog2(DATA_WIDTH);

  logic [DATA_WIDTH-1:0] op_a;
  logic [DATA_WIDTH-1:0] op_b;
  logic [SHAMT_W-1:0]    shamt;
  logic [DATA_WIDTH-1:0] result;

  // operand addresses straight from the issue fields
  assign rd.raddr_a = alu_rs1_i;
  assign rd.raddr_b = alu_rs2_i;

  assign op_a  = rd.rdata_a;
  assign op_b  = rd.rdata_b;
  assign shamt = op_b[SHAMT_W-1:0];

  // opcode decode
  always_comb begin
    case (alu_op_i)
      rf_pkg::OP_LI:  result = alu_imm_i;
      rf_pkg::OP_ADD: result = op_a + op_b;
      rf_pkg::OP_SUB: result = op_a - op_b;
      rf_pkg::OP_AND: result = op_a & op_b;
      rf_pkg::OP_OR:  result = op_a | op_b;
      rf_pkg::OP_XOR: result = op_a ^ op_b;
      // logical shifts, zero fill
      rf_pkg::OP_SLL: result = op_a << shamt;
      rf_pkg::OP_SRL: result = op_a >> shamt;
      default:        result = '0;
    endcase
  end

  // no back-pressure, every valid cycle is a write
  assign we_o    = alu_valid_i;
  assign waddr_o = alu_rd_i;
  assign wdata_o = result;

endmodule

`default_nettype wire

//--- mul_lane.sv
/*
 * iterative shift-add multiply lane writing the low half of the product into rd
 * DATA_WIDTH run cycles after acceptance, then one write-back cycle on port 1
 */
`timescale 1ns/10ps
`default_nettype none

module mul_lane #(
  parameter int unsigned DATA_WIDTH = 32,
  parameter int unsigned ADDR_WIDTH = 5
) (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,
  // issue held by the issuer until ready
  input  wire logic                  mul_valid_i,
  input  wire logic                  mul_ready_i,
  input  wire logic [ADDR_WIDTH-1:0] mul_rd_i,
  input  wire logic [ADDR_WIDTH-1:0] mul_rs1_i,
  input  wire logic [ADDR_WIDTH-1:0] mul_rs2_i,
  // operand read through the arbiter
  rf_read_if.requester               rd,
  // status
  output logic                       busy_o,
  output logic                       done_o,
  // write port 1
  output logic                       we_o,
  output logic      [ADDR_WIDTH-1:0] waddr_o,
  output logic      [DATA_WIDTH-1:0] wdata_o
);

  localparam int unsigned CNT_W = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;

  rf_pkg::mul_state_e state_q;
  rf_pkg::mul_state_e state_d;
  logic [CNT_W-1:0]      cnt_q;
  logic                  accept;
  logic                  last_step;

  // shift-add datapath
  logic [DATA_WIDTH-1:0] mcand_q;
  logic [DATA_WIDTH-1:0] mplier_q;
  logic [DATA_WIDTH-1:0] acc_q;
  logic [ADDR_WIDTH-1:0] rd_q;

  // operands are read in the accept cycle
  assign rd.raddr_a = mul_rs1_i;
  assign rd.raddr_b = mul_rs2_i;

  assign accept    = mul_valid_i && mul_ready_i && (state_q == rf_pkg::MUL_IDLE);
  assign last_step = (cnt_q == '0);

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      rf_pkg::MUL_IDLE: if (accept)    state_d = rf_pkg::MUL_RUN;
      rf_pkg::MUL_RUN:  if (last_step) state_d = rf_pkg::MUL_WB;
      rf_pkg::MUL_WB:   state_d = rf_pkg::MUL_IDLE;
      default:          state_d = rf_pkg::MUL_IDLE;
    endcase
  end

  // state and step counter
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= rf_pkg::MUL_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        // counts DATA_WIDTH run cycles down to zero
        cnt_q <= CNT_W'(DATA_WIDTH - 1);
      end else if (state_q == rf_pkg::MUL_RUN) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // shift-add step
  // multiplicand moves left, multiplier right, low bit gates the add
  always_ff @(posedge clk_i) begin
    if (accept) begin
      mcand_q  <= rd.rdata_a;
      mplier_q <= rd.rdata_b;
      acc_q    <= '0;
      rd_q     <= mul_rd_i;
    end else if (state_q == rf_pkg::MUL_RUN) begin
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  assign busy_o  = (state_q != rf_pkg::MUL_IDLE);
  // write-back lasts exactly one cycle
  assign done_o  = (state_q == rf_pkg::MUL_WB);
  assign we_o    = done_o;
  assign waddr_o = rd_q;
  assign wdata_o = acc_q;

endmodule

`default_nettype wire

//--- rf_exec_top.sv
/*
 * two-lane integer execution top, ALU and multiply lanes on a shared register file
 * plain-port wrapper, drive issue strobes and watch results on the debug port
 */
`timescale 1ns/10ps
`default_nettype none

module rf_exec_top #(
  parameter int unsigned DATA_WIDTH    = 32,
  parameter int unsigned ADDR_WIDTH    = 5,
  parameter bit          ZERO_REG_ZERO = 1'b1
) (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,
  // ALU issue
  input  wire logic                  alu_valid_i,
  input  wire rf_pkg::alu_op_e       alu_op_i,
  input  wire logic [ADDR_WIDTH-1:0] alu_rd_i,
  input  wire logic [ADDR_WIDTH-1:0] alu_rs1_i,
  input  wire logic [ADDR_WIDTH-1:0] alu_rs2_i,
  input  wire logic [DATA_WIDTH-1:0] alu_imm_i,
  // multiply issue and status
  input  wire logic                  mul_valid_i,
  input  wire logic [ADDR_WIDTH-1:0] mul_rd_i,
  input  wire logic [ADDR_WIDTH-1:0] mul_rs1_i,
  input  wire logic [ADDR_WIDTH-1:0] mul_rs2_i,
  output logic                       mul_ready_o,
  output logic                       mul_done_o,
  // debug read
  input  wire logic [ADDR_WIDTH-1:0] dbg_raddr_i,
  output logic      [DATA_WIDTH-1:0] dbg_rdata_o
);

  // write ports gathered by index
  logic [rf_pkg::NUM_WR_PORTS-1:0]                 we;
  logic [rf_pkg::NUM_WR_PORTS-1:0][ADDR_WIDTH-1:0] waddr;
  logic [rf_pkg::NUM_WR_PORTS-1:0][DATA_WIDTH-1:0] wdata;
  logic                                            mul_busy;

  // lane read ports and the shared register file pair
  rf_read_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) alu_rd ();
  rf_read_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) mul_rd ();
  rf_read_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) rf_rd ();

  alu_lane #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_alu_lane (
    .alu_valid_i (alu_valid_i),
    .alu_op_i    (alu_op_i),
    .alu_rd_i    (alu_rd_i),
    .alu_rs1_i   (alu_rs1_i),
    .alu_rs2_i   (alu_rs2_i),
    .alu_imm_i   (alu_imm_i),
    .rd          (alu_rd.requester),
    .we_o        (we[rf_pkg::WR_PORT_ALU]),
    .waddr_o     (waddr[rf_pkg::WR_PORT_ALU]),
    .wdata_o     (wdata[rf_pkg::WR_PORT_ALU])
  );

  // multiply on the higher write port, so it wins collisions
  mul_lane #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_mul_lane (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .mul_valid_i (mul_valid_i),
    .mul_ready_i (mul_ready_o),
    .mul_rd_i    (mul_rd_i),
    .mul_rs1_i   (mul_rs1_i),
    .mul_rs2_i   (mul_rs2_i),
    .rd          (mul_rd.requester),
    .busy_o      (mul_busy),
    .done_o      (mul_done_o),
    .we_o        (we[rf_pkg::WR_PORT_MUL]),
    .waddr_o     (waddr[rf_pkg::WR_PORT_MUL]),
    .wdata_o     (wdata[rf_pkg::WR_PORT_MUL])
  );

  rf_read_arbiter u_rf_read_arbiter (
    .alu_valid_i (alu_valid_i),
    .alu_rd      (alu_rd.provider),
    .mul_rd      (mul_rd.provider),
    .rf_rd       (rf_rd.requester),
    .mul_busy_i  (mul_busy),
    .mul_ready_o (mul_ready_o)
  );

  rf_lvt_regfile #(
    .DATA_WIDTH    (DATA_WIDTH),
    .ADDR_WIDTH    (ADDR_WIDTH),
    .ZERO_REG_ZERO (ZERO_REG_ZERO)
  ) u_rf_lvt_regfile (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .rd          (rf_rd.provider),
    .we_i        (we),
    .waddr_i     (waddr),
    .wdata_i     (wdata),
    .dbg_raddr_i (dbg_raddr_i),
    .dbg_rdata_o (dbg_rdata_o)
  );

endmodule

`default_nettype wire

//--- tb_rf_exec.sv
/*
 * self-checking testbench for rf_exec_top, a shadow register array predicts every register
 * stimulus on the falling edge, results read back through the debug port
 */
`timescale 1ns/10ps
`default_nettype none

module tb_rf_exec;

  localparam int DW           = 32;
  localparam int AW           = 5;
  localparam int NUM_REGS     = 2 ** AW;
  localparam int SHAMT_W      = $clog2(DW);
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 10;
  localparam int N_LOAD       = 16;
  localparam int N_ALU        = 48;
  localparam int N_MUL        = 6;
  localparam int N_ARB        = 2;
  localparam int WAIT_LIMIT   = 8;
  // accept wait, DW run cycles, write-back, one read-back cycle
  localparam int MUL_CYCLES   = DW + 4;
  localparam int NUM_MULS     = N_MUL + N_ARB + 4;
  localparam int BUDGET       = RESET_CYCLES + 3 * NUM_REGS + N_LOAD + 2 + N_ALU + 1
                                + NUM_MULS * MUL_CYCLES + N_ARB * 4 + 8;

  logic                  clk_i;
  logic                  arst_n_i;
  logic                  alu_valid_i;
  rf_pkg::alu_op_e       alu_op_i;
  logic [AW-1:0]         alu_rd_i, alu_rs1_i, alu_rs2_i;
  logic [DW-1:0]         alu_imm_i;
  logic                  mul_valid_i;
  logic [AW-1:0]         mul_rd_i, mul_rs1_i, mul_rs2_i;
  logic                  mul_ready_o;
  logic                  mul_done_o;
  logic [AW-1:0]         dbg_raddr_i;
  logic [DW-1:0]         dbg_rdata_o;

  // shadow registers, rng state and counters
  logic [DW-1:0] model [NUM_REGS];
  logic [31:0]   rng;
  int            checks;
  int            errors;

  rf_exec_top #(.DATA_WIDTH(DW), .ADDR_WIDTH(AW), .ZERO_REG_ZERO(1'b1)) DUT (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // the ALU owns the read pair, so no multiply can be accepted
  ready_blocked_by_alu: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) alu_valid_i |-> !mul_ready_o)
  else begin
    $display("MISMATCH at %0t: mul_ready_o high while the ALU issues", $time);
    errors++;
  end

  // write-back strobe is a single-cycle pulse
  done_single_cycle: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) mul_done_o |=> !mul_done_o)
  else begin
    $display("MISMATCH at %0t: mul_done_o high for more than one cycle", $time);
    errors++;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // register 0 reads zero whatever was written to it
  function automatic logic [DW-1:0] reg_value(input logic [AW-1:0] a);
    return (a == '0) ? '0 : model[a];
  endfunction

  function automatic logic [DW-1:0] expect_alu(input rf_pkg::alu_op_e op,
                                               input logic [DW-1:0] a, b, imm);
    case (op)
      rf_pkg::OP_LI:  return imm;
      rf_pkg::OP_ADD: return a + b;
      rf_pkg::OP_SUB: return a - b;
      rf_pkg::OP_AND: return a & b;
      rf_pkg::OP_OR:  return a | b;
      rf_pkg::OP_XOR: return a ^ b;
      rf_pkg::OP_SLL: return a << b[SHAMT_W-1:0];
      rf_pkg::OP_SRL: return a >> b[SHAMT_W-1:0];
      default:        return '0;
    endcase
  endfunction

  task automatic check_eq(input string what, input logic [DW-1:0] got, input logic [DW-1:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // called at a falling edge, debug read settles within the low phase
  task automatic read_check(input logic [AW-1:0] a);
    dbg_raddr_i = a;
    #1;
    check_eq($sformatf("r%0d", a), dbg_rdata_o, reg_value(a));
  endtask

  task automatic idle_check(input logic [AW-1:0] a);
    @(negedge clk_i);
    alu_valid_i = 1'b0;
    read_check(a);
  endtask

  task automatic sweep_regs();
    for (int a = 0; a < NUM_REGS; a++) begin
      idle_check(AW'(a));
    end
  endtask

  // one ALU issue at the current falling edge, an earlier result is checked meanwhile
  task automatic alu_drive(input rf_pkg::alu_op_e op, input logic [AW-1:0] rd, rs1, rs2,
                           input logic [DW-1:0] imm, input logic [AW-1:0] chk);
    logic [DW-1:0] res;
    res         = expect_alu(op, reg_value(rs1), reg_value(rs2), imm);
    alu_valid_i = 1'b1;
    alu_op_i    = op;
    alu_rd_i    = rd;
    alu_rs1_i   = rs1;
    alu_rs2_i   = rs2;
    alu_imm_i   = imm;
    read_check(chk);
    // lands at the coming rising edge
    model[rd] = res;
  endtask

  task automatic mul_arm(input logic [AW-1:0] rd, rs1, rs2);
    mul_valid_i = 1'b1;
    mul_rd_i    = rd;
    mul_rs1_i   = rs1;
    mul_rs2_i   = rs2;
  endtask

  // waits for acceptance, then follows the multiply edge by edge
  task automatic mul_complete(input bit collide, input logic [DW-1:0] alu_imm);
    logic [2*DW-1:0] full;
    logic [DW-1:0]   product;
    logic [AW-1:0]   rd;
    int              waited;
    waited = 0;
    #1;
    while (!mul_ready_o && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!mul_ready_o) begin
      $display("multiply request at %0t was never accepted, ready stayed low", $time);
      errors++;
      mul_valid_i = 1'b0;
      return;
    end
    // operands as the registers stand at the acceptance edge
    rd      = mul_rd_i;
    full    = {{DW{1'b0}}, reg_value(mul_rs1_i)} * {{DW{1'b0}}, reg_value(mul_rs2_i)};
    product = full[DW-1:0];
    for (int k = 1; k <= DW + 2; k++) begin
      @(negedge clk_i);
      mul_valid_i = 1'b0;
      alu_valid_i = 1'b0;
      dbg_raddr_i = rd;
      if (collide && k == DW + 1) begin
        // ALU write to the same register at the multiply write edge
        alu_valid_i = 1'b1;
        alu_op_i    = rf_pkg::OP_LI;
        alu_rd_i    = rd;
        alu_imm_i   = alu_imm;
      end
      #1;
      check_eq("mul_done_o", DW'(mul_done_o), DW'(k == DW + 1));
      check_eq("mul_ready_o", DW'(mul_ready_o), DW'(k == DW + 2));
    end
    // higher write port wins the collision
    model[rd] = product;
    check_eq($sformatf("r%0d after multiply", rd), dbg_rdata_o, reg_value(rd));
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %s finished with %0d errors", name, errors - errs_before);
  endtask

  initial begin
    int              eb;
    logic [31:0]     r;
    logic [AW-1:0]   rd, rs1, rs2, prev;
    rf_pkg::alu_op_e op;
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    alu_valid_i = 1'b0;
    alu_op_i    = rf_pkg::OP_LI;
    alu_rd_i    = '0;
    alu_rs1_i   = '0;
    alu_rs2_i   = '0;
    alu_imm_i   = '0;
    mul_valid_i = 1'b0;
    mul_rd_i    = '0;
    mul_rs1_i   = '0;
    mul_rs2_i   = '0;
    dbg_raddr_i = '0;
    rng         = 32'h16ddd01a;
    checks      = 0;
    errors      = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    // reset state, then loads with register 0 written too
    eb = errors;
    #1;
    check_eq("mul_done_o after reset", DW'(mul_done_o), '0);
    check_eq("mul_ready_o after reset", DW'(mul_ready_o), DW'(1));
    sweep_regs();
    prev = '0;
    for (int i = 0; i < N_LOAD; i++) begin
      rd = AW'(next_rand() >> 7);
      @(negedge clk_i);
      alu_drive(rf_pkg::OP_LI, rd, '0, '0, next_rand(), prev);
      prev = rd;
    end
    @(negedge clk_i);
    alu_drive(rf_pkg::OP_LI, '0, '0, '0, 32'hffff_ffff, prev);
    @(negedge clk_i);
    alu_valid_i = 1'b0;
    read_check('0);
    check_eq("r0 hardwired", dbg_rdata_o, '0);
    sweep_regs();
    report_test("load and zero register", eb);

    // back-to-back ALU issues, all opcodes first
    eb = errors;
    for (int i = 0; i < N_ALU; i++) begin
      r   = next_rand();
      op  = (i < 8) ? rf_pkg::alu_op_e'(i) : rf_pkg::alu_op_e'(r[2:0]);
      // often rs1 is the result of the issue just before
      rs1 = r[3] ? prev : r[8 +: AW];
      @(negedge clk_i);
      alu_drive(op, r[16 +: AW], rs1, r[24 +: AW], next_rand(), prev);
      prev = r[16 +: AW];
    end
    idle_check(prev);
    report_test("ALU operations", eb);

    eb = errors;
    for (int i = 0; i < N_MUL; i++) begin
      r = next_rand();
      @(negedge clk_i);
      alu_valid_i = 1'b0;
      mul_arm(r[0 +: AW], r[8 +: AW], r[16 +: AW]);
      mul_complete(1'b0, '0);
    end
    report_test("multiply", eb);

    // request held through a three-cycle ALU burst
    eb = errors;
    for (int i = 0; i < N_ARB; i++) begin
      r   = next_rand();
      rs1 = r[0 +: AW];
      rs2 = r[8 +: AW];
      rd  = r[16 +: AW];
      @(negedge clk_i);
      mul_arm(rd, rs1, rs2);
      alu_drive(rf_pkg::OP_LI, rs1, '0, '0, next_rand(), rd);
      @(negedge clk_i);
      alu_drive(rf_pkg::OP_LI, rs2, '0, '0, next_rand(), rs1);
      // rs1 rewritten on the last edge before acceptance
      @(negedge clk_i);
      alu_drive(rf_pkg::OP_XOR, rs1, rs1, rs2, '0, rs2);
      @(negedge clk_i);
      alu_valid_i = 1'b0;
      #1;
      check_eq("mul_ready_o after ALU burst", DW'(mul_ready_o), DW'(1));
      mul_complete(1'b0, '0);
    end
    report_test("arbitration", eb);

    // lvt ordering both ways, then same-edge collisions
    eb = errors;
    r  = next_rand();
    rd = r[0 +: AW] | AW'(1);
    @(negedge clk_i);
    alu_valid_i = 1'b0;
    mul_arm(rd, r[8 +: AW], r[16 +: AW]);
    mul_complete(1'b0, '0);
    @(negedge clk_i);
    alu_drive(rf_pkg::OP_LI, rd, '0, '0, next_rand(), rd);
    idle_check(rd);
    @(negedge clk_i);
    alu_drive(rf_pkg::OP_LI, rd, '0, '0, next_rand(), rd);
    @(negedge clk_i);
    alu_valid_i = 1'b0;
    mul_arm(rd, r[8 +: AW], r[24 +: AW]);
    mul_complete(1'b0, '0);
    for (int i = 0; i < 2; i++) begin
      r = next_rand();
      @(negedge clk_i);
      alu_valid_i = 1'b0;
      mul_arm(r[0 +: AW] | AW'(1), r[8 +: AW], r[16 +: AW]);
      mul_complete(1'b1, next_rand());
    end
    sweep_regs();
    report_test("live value table and collisions", eb);

    $display("summary: %0d checks, %0d failures", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // twice the cycle budget of all tests
  initial begin
    #(BUDGET * 2 * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run is stuck", 2 * BUDGET);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
rf_pkg.sv
rf_read_if.sv
rf_lvt_regfile.sv
rf_read_arbiter.sv
alu_lane.sv
mul_lane.sv
rf_exec_top.sv
tb_rf_exec.sv

//--- run.sh
#!/bin/sh
# build the testbench and RTL from verilog.f with Verilator, run it and look for the pass line
verilator --binary --timing --assert --timescale 1ns/10ps -f verilog.f \
  --top-module tb_rf_exec -o sim_rf_exec \
  && ./obj_dir/sim_rf_exec | tee /dev/stderr | grep -q "All checks passed" \
  && echo "simulation PASSED" \
  || { echo "simulation FAILED"; exit 1; }
